//--- oflow_core.f
verilog/oflow_core_pkg.sv
verilog/oflow_mem_pkg.sv
verilog/oflow_set_divider.sv
verilog/oflow_core_fsm.sv
verilog/oflow_pe_engine.sv
verilog/oflow_frame_buffer.sv
verilog/oflow_match_resolve.sv
verilog/oflow_core_top.sv
test/oflow_core_checker.sv
test/oflow_core_tb.sv

//--- test/oflow_core_checker.sv
// fsm control pulse assertions
module oflow_core_checker import oflow_core_pkg::*; (
	input logic        clk,
	input logic        reset_N,
	input core_state_t state,
	input logic        ready_new_frame,
	input logic        start_pe,
	input logic        start_cr,
	input logic        start_write_mem,
	input logic        valid_id,
	input logic        conflict_counter_th
);

	// number of failed assertions so far
	int unsigned assert_failures = 0;

	// ------------------------------------------------------------------
	// start strobes, one cycle each
	// ------------------------------------------------------------------
	start_pe_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		start_pe |=> !start_pe)
		else begin
			$error("start_pe held for more than one cycle");
			assert_failures++;
		end

	start_cr_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		start_cr |=> !start_cr)
		else begin
			$error("start_cr held for more than one cycle");
			assert_failures++;
		end

	start_write_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		start_write_mem |=> !start_write_mem)
		else begin
			$error("start_write_mem held for more than one cycle");
			assert_failures++;
		end

	// a frame ends either committed or dropped, never both
	end_exclusive: assert property (@(posedge clk) disable iff (!reset_N)
		!(valid_id && conflict_counter_th))
		else begin
			$error("valid_id and conflict_counter_th in the same cycle");
			assert_failures++;
		end

	// frame request only from idle
	ready_in_idle: assert property (@(posedge clk) disable iff (!reset_N)
		ready_new_frame |-> state == idle_st)
		else begin
			$error("ready_new_frame high outside idle");
			assert_failures++;
		end

endmodule

//--- test/oflow_core_tb.sv
// optical flow core testbench
module oflow_core_tb import oflow_core_pkg::*; import oflow_mem_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int NUM_FRAMES = 14;
	// idle wait, divide, sets with gaps, scan, write
	localparam int FRAME_CYCLES = (BBOX_CNT_W + 4) + 2 * (MAX_BBOX / PE_NUM) + 3
	                            + (MAX_BBOX + 3) + 4;
	localparam int TIMEOUT = (16 + 2 * NUM_FRAMES * FRAME_CYCLES) * CLK_PERIOD;
	localparam int NEAR_MODE = 0;
	localparam int MIX_MODE = 1;
	localparam int FAR_MODE = 2;

	logic                           clk;
	logic                           reset_N;
	logic                           start;
	logic                           new_frame_from_dma;
	logic                           new_set_from_dma;
	logic [BBOX_CNT_W-1:0]          num_of_bbox_in_frame;
	logic [PE_NUM-1:0][COORD_W-1:0] set_x;
	logic [PE_NUM-1:0][COORD_W-1:0] set_y;
	logic                           ready_new_frame;
	logic                           ready_new_set;
	logic                           valid_id;
	logic [FRAME_NUM_W-1:0]         frame_num;
	logic [MAX_BBOX-1:0]            match_mask;
	logic                           frame_dropped;

	integer                 seed;
	int                     frames_checked;
	// reference model state
	logic [COORD_W-1:0]     new_x [MAX_BBOX];
	logic [COORD_W-1:0]     new_y [MAX_BBOX];
	logic [COORD_W-1:0]     cur_x [MAX_BBOX];
	logic [COORD_W-1:0]     cur_y [MAX_BBOX];
	logic [COORD_W-1:0]     hist_x [MAX_BBOX];
	logic [COORD_W-1:0]     hist_y [MAX_BBOX];
	logic [FRAME_NUM_W-1:0] frame_cnt;
	// expected results, one entry per frame in flight
	logic [MAX_BBOX-1:0]    exp_mask_q [$];
	bit                     exp_drop_q [$];
	logic [FRAME_NUM_W-1:0] exp_frame_q [$];

	oflow_core_top dut (.*);

	bind oflow_core_fsm oflow_core_checker u_checker (
		.clk                 (clk),
		.reset_N             (reset_N),
		.state               (state),
		.ready_new_frame     (ready_new_frame),
		.start_pe            (start_pe),
		.start_cr            (start_cr),
		.start_write_mem     (start_write_mem),
		.valid_id            (valid_id),
		.conflict_counter_th (conflict_counter_th)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------
	// helpers and reference model
	// ------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// small move toward the middle of the coordinate range
	function automatic logic [COORD_W-1:0] nudge(input logic [COORD_W-1:0] c, input int span);
		logic [COORD_W-1:0] step;
		step = COORD_W'(rand_below(span));
		return c[COORD_W-1] ? c - step : c + step;
	endfunction

	function automatic logic [DIST_W-1:0] coord_diff(input logic [COORD_W-1:0] a,
	                                                 input logic [COORD_W-1:0] b);
		return (a > b) ? DIST_W'(a - b) : DIST_W'(b - a);
	endfunction

	// manhattan rule, slot against the same history slot
	function automatic logic [MAX_BBOX-1:0] expected_mask(input int count);
		logic [MAX_BBOX-1:0] mask;
		mask = '0;
		for (int i = 0; i < count; i++)
			mask[i] = (coord_diff(new_x[i], hist_x[i]) + coord_diff(new_y[i], hist_y[i]))
			          <= DIST_W'(MATCH_TH);
		return mask;
	endfunction

	task automatic run_frame(input int mode, input int count);
		int                  nsets;
		int                  sent;
		int                  unmatched;
		bit                  skipped;
		bit                  drop;
		logic [MAX_BBOX-1:0] mask;
		nsets = (count + PE_NUM - 1) / PE_NUM;
		for (int i = 0; i < MAX_BBOX; i++) begin
			if (mode == FAR_MODE) begin
				new_x[i] = hist_x[i] ^ 8'h80;
				new_y[i] = hist_y[i] ^ 8'h80;
			end else begin
				new_x[i] = nudge(hist_x[i], (mode == NEAR_MODE) ? 8 : 16);
				new_y[i] = nudge(hist_y[i], (mode == NEAR_MODE) ? 8 : 16);
			end
		end
		mask = expected_mask(count);
		unmatched = 0;
		for (int i = 0; i < count; i++)
			if (!mask[i])
				unmatched++;
		// no resolve step right after reset or a drop
		drop = (frame_cnt != '0) && (unmatched > CONFLICT_TH);
		exp_mask_q.push_back(mask);
		exp_drop_q.push_back(drop);
		exp_frame_q.push_back(frame_cnt);
		// every lane of a sent set lands in current
		for (int i = 0; i < nsets * PE_NUM; i++) begin
			cur_x[i] = new_x[i];
			cur_y[i] = new_y[i];
		end
		if (drop) begin
			frame_cnt = '0;
		end else begin
			hist_x = cur_x;
			hist_y = cur_y;
			frame_cnt = frame_cnt + 1'b1;
		end

		// frame strobe from either source
		while (!ready_new_frame)
			@(negedge clk);
		num_of_bbox_in_frame = BBOX_CNT_W'(count);
		if (rand_below(2) == 0)
			start = 1'b1;
		else
			new_frame_from_dma = 1'b1;
		@(negedge clk);
		start = 1'b0;
		new_frame_from_dma = 1'b0;
		sent = 0;
		skipped = 0;
		while (!(valid_id || frame_dropped)) begin
			new_set_from_dma = 1'b0;
			if (ready_new_set && (skipped || rand_below(4) != 0)) begin
				for (int l = 0; l < PE_NUM; l++) begin
					set_x[l] = new_x[sent * PE_NUM + l];
					set_y[l] = new_y[sent * PE_NUM + l];
				end
				new_set_from_dma = 1'b1;
				sent++;
				skipped = 0;
			end else if (ready_new_set) begin
				// one idle gap at most
				skipped = 1;
			end else if (rand_below(3) == 0) begin
				// junk set while not ready, must be ignored
				set_x = {$random(seed)};
				set_y = {$random(seed)};
				new_set_from_dma = 1'b1;
			end
			@(negedge clk);
		end
		new_set_from_dma = 1'b0;
		check_value("sets_requested", sent, nsets);
	endtask

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin : stimulus
		int f;
		seed = 71572;
		reset_N = 1'b0;
		start = 1'b0;
		new_frame_from_dma = 1'b0;
		new_set_from_dma = 1'b0;
		num_of_bbox_in_frame = '0;
		set_x = '0;
		set_y = '0;
		frame_cnt = '0;
		for (int i = 0; i < MAX_BBOX; i++) begin
			cur_x[i] = '0;
			cur_y[i] = '0;
			hist_x[i] = '0;
			hist_y[i] = '0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b1;
		// zero history, partial last set
		run_frame(MIX_MODE, 7);
		run_frame(NEAR_MODE, 16);
		run_frame(NEAR_MODE, 10);
		// everything far, dropped
		run_frame(FAR_MODE, 16);
		// compares against the last committed frame
		run_frame(NEAR_MODE, 13);
		for (f = 5; f < NUM_FRAMES; f++)
			run_frame(rand_below(3), 1 + rand_below(MAX_BBOX));
		repeat (4) @(negedge clk);
		if (frames_checked == NUM_FRAMES && exp_mask_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			abort_run("run ended with frames left unchecked");
		end
	end

	// frame results, sampled away from the active edge
	initial begin : compare
		logic [MAX_BBOX-1:0]    mask;
		bit                     drop;
		logic [FRAME_NUM_W-1:0] fnum;
		frames_checked = 0;
		forever begin
			@(negedge clk);
			if (dut.u_fsm.u_checker.assert_failures != 0)
				abort_run("an fsm assertion failed");
			if (valid_id || frame_dropped) begin
				if (exp_mask_q.size() == 0)
					abort_run("frame ended with no frame pending");
				mask = exp_mask_q.pop_front();
				drop = exp_drop_q.pop_front();
				fnum = exp_frame_q.pop_front();
				check_value("frame_dropped", frame_dropped, drop);
				if (drop) begin
					check_value("valid_id", valid_id, 1'b0);
				end else begin
					check_value("match_mask", match_mask, mask);
					check_value("frame_num", frame_num, fnum);
				end
				frames_checked++;
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT);
		abort_run("timeout, frames did not finish in time");
	end

endmodule

//--- verilog/oflow_core_fsm.sv
// core frame state machine
module oflow_core_fsm import oflow_core_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   start,
	input  logic                   new_frame_from_dma,
	input  logic                   new_set_from_dma,
	input  logic [BBOX_CNT_W-1:0]  num_of_bbox_in_frame,
	input  logic                   done_pe,
	input  logic                   done_cr,
	input  logic                   conflict_counter_th,
	input  logic                   done_write,
	output logic                   ready_new_frame,
	output logic                   ready_new_set,
	output logic                   start_pe,
	output logic                   start_cr,
	output logic                   start_write_mem,
	output logic                   valid_id,
	output logic [FRAME_NUM_W-1:0] frame_num,
	output logic [SET_W-1:0]       num_of_sets,
	output logic [BBOX_CNT_W-1:0]  counter_of_remain_bboxes
);

	core_state_t state;
	core_state_t next_state;

	logic                  start_div;
	logic                  div_complete;
	logic                  div_complete_d;
	logic                  div_rise;
	logic [BBOX_CNT_W-1:0] quotient;
	logic [BBOX_CNT_W-1:0] remainder;
	logic [SET_W-1:0]      quotient_reg;
	logic [BBOX_CNT_W-1:0] remainder_reg;
	logic                  set_accept;

	// ------------------------------------------------------------------
	// box count / PE_NUM
	// ------------------------------------------------------------------
	oflow_set_divider u_divider (
		.clk          (clk),
		.reset_N      (reset_N),
		.start_div    (start_div),
		.dividend     (num_of_bbox_in_frame),
		.div_complete (div_complete),
		.quotient     (quotient),
		.remainder    (remainder)
	);

	// complete is a level, only its rising edge counts
	assign div_rise = div_complete & ~div_complete_d;

	// partial last set needs one more
	assign num_of_sets = quotient_reg + SET_W'(remainder_reg != '0);

	assign ready_new_set = (state == pe_st) && (counter_of_remain_bboxes != '0);
	assign set_accept    = new_set_from_dma & ready_new_set;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state          <= idle_st;
			div_complete_d <= 1'b0;
			start_div      <= 1'b0;
			valid_id       <= 1'b0;
		end else begin
			state          <= next_state;
			div_complete_d <= div_complete;
			// divider kick on leaving idle
			start_div      <= (state == idle_st) && (next_state == set_variables_st);
			// one cycle, first cycle of write
			valid_id       <= (state != write_st) && (next_state == write_st);
		end
	end

	// quotient and remainder latched on the complete edge
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			quotient_reg  <= '0;
			remainder_reg <= '0;
		end else if (state == set_variables_st && div_rise) begin
			quotient_reg  <= quotient[SET_W-1:0];
			remainder_reg <= remainder;
		end
	end

	// boxes still to be delivered in this frame
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			counter_of_remain_bboxes <= '0;
		end else if (state == set_variables_st) begin
			counter_of_remain_bboxes <= num_of_bbox_in_frame;
		end else if (state == pe_st && set_accept) begin
			if (counter_of_remain_bboxes > BBOX_CNT_W'(PE_NUM))
				counter_of_remain_bboxes <= counter_of_remain_bboxes - BBOX_CNT_W'(PE_NUM);
			else
				counter_of_remain_bboxes <= '0;
		end
	end

	// committed frames, back to zero on a drop
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			frame_num <= '0;
		else if (state == conflict_resolve_st && conflict_counter_th)
			frame_num <= '0;
		else if (state == write_st && done_write)
			frame_num <= frame_num + 1'b1;
	end

	// ------------------------------------------------------------------
	// next state and start pulses
	// ------------------------------------------------------------------
	always_comb begin
		next_state      = state;
		ready_new_frame = 1'b0;
		start_pe        = 1'b0;
		start_cr        = 1'b0;
		start_write_mem = 1'b0;
		case (state)
			idle_st: begin
				ready_new_frame = 1'b1;
				if (start || new_frame_from_dma)
					next_state = set_variables_st;
			end
			set_variables_st: begin
				if (div_rise) begin
					start_pe   = 1'b1;
					next_state = pe_st;
				end
			end
			pe_st: begin
				// first frame has no history to resolve against
				if (done_pe && frame_num == '0) begin
					start_write_mem = 1'b1;
					next_state      = write_st;
				end else if (done_pe) begin
					start_cr   = 1'b1;
					next_state = conflict_resolve_st;
				end
			end
			conflict_resolve_st: begin
				if (conflict_counter_th) begin
					next_state = idle_st;
				end else if (done_cr) begin
					start_write_mem = 1'b1;
					next_state      = write_st;
				end
			end
			write_st: begin
				if (done_write)
					next_state = idle_st;
			end
			default: next_state = idle_st;
		endcase
	end

endmodule

//--- verilog/oflow_core_pkg.sv
// optical flow core control constants
package oflow_core_pkg;

	// ------------------------------------------------------------------
	// frame and set geometry
	// ------------------------------------------------------------------
	// lanes per set
	localparam int PE_NUM = 4;
	// boxes per frame, upper bound
	localparam int MAX_BBOX = 16;
	// box count, 0 to MAX_BBOX
	localparam int BBOX_CNT_W = 5;
	// set count, 0 to MAX_BBOX / PE_NUM
	localparam int SET_W = 3;
	// committed frame counter
	localparam int FRAME_NUM_W = 8;
	// more unmatched boxes than this drops the frame
	localparam int CONFLICT_TH = 8;

	// ------------------------------------------------------------------
	// core fsm states
	// ------------------------------------------------------------------
	typedef enum logic [2:0] {
		idle_st,
		set_variables_st,
		pe_st,
		conflict_resolve_st,
		write_st
	} core_state_t;

endpackage

//--- verilog/oflow_core_top.sv
// optical flow tracker core top
module oflow_core_top import oflow_core_pkg::*; import oflow_mem_pkg::*; (
	input  logic                            clk,
	input  logic                            reset_N,
	input  logic                            start,
	input  logic                            new_frame_from_dma,
	input  logic                            new_set_from_dma,
	input  logic [BBOX_CNT_W-1:0]          num_of_bbox_in_frame,
	input  logic [PE_NUM-1:0][COORD_W-1:0] set_x,
	input  logic [PE_NUM-1:0][COORD_W-1:0] set_y,
	output logic                            ready_new_frame,
	output logic                            ready_new_set,
	output logic                            valid_id,
	output logic [FRAME_NUM_W-1:0]         frame_num,
	output logic [MAX_BBOX-1:0]            match_mask,
	output logic                            frame_dropped
);

	logic                           start_pe, start_cr, start_write_mem;
	logic                           done_pe, done_cr, done_write;
	logic                           conflict_counter_th;
	logic [SET_W-1:0]               num_of_sets;
	logic [SET_W-1:0]               set_index;
	logic [BBOX_CNT_W-1:0]          counter_of_remain_bboxes;
	logic [PE_NUM-1:0][COORD_W-1:0] hist_x, hist_y;
	logic [PE_NUM-1:0][DIST_W-1:0]  lane_dist;
	logic [PE_NUM-1:0]              lane_valid;
	logic                           dist_valid;

	// drop decision leaves as the frame end marker
	assign frame_dropped = conflict_counter_th;

	oflow_core_fsm u_fsm (.*);

	oflow_pe_engine u_engine (.*);

	oflow_frame_buffer u_buffer (.*);

	oflow_match_resolve u_resolve (.*);

endmodule

//--- verilog/oflow_frame_buffer.sv
// current and history box memories
module oflow_frame_buffer import oflow_core_pkg::*; import oflow_mem_pkg::*; (
	input  logic                            clk,
	input  logic                            reset_N,
	input  logic [SET_W-1:0]               set_index,
	input  logic                            new_set_from_dma,
	input  logic                            ready_new_set,
	input  logic [PE_NUM-1:0][COORD_W-1:0] set_x,
	input  logic [PE_NUM-1:0][COORD_W-1:0] set_y,
	input  logic                            start_write_mem,
	output logic [PE_NUM-1:0][COORD_W-1:0] hist_x,
	output logic [PE_NUM-1:0][COORD_W-1:0] hist_y,
	output logic                            done_write
);

	logic [MAX_BBOX-1:0][COORD_W-1:0] cur_mem_x;
	logic [MAX_BBOX-1:0][COORD_W-1:0] cur_mem_y;
	logic [MAX_BBOX-1:0][COORD_W-1:0] hist_mem_x;
	logic [MAX_BBOX-1:0][COORD_W-1:0] hist_mem_y;
	logic [BBOX_ADDR_W-1:0]           base_addr;

	// first slot of the set
	assign base_addr = BBOX_ADDR_W'(set_index * PE_NUM);

	// history read, same set slot as the incoming boxes
	always_comb begin
		for (int i = 0; i < PE_NUM; i++) begin
			hist_x[i] = hist_mem_x[base_addr + BBOX_ADDR_W'(i)];
			hist_y[i] = hist_mem_y[base_addr + BBOX_ADDR_W'(i)];
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			cur_mem_x  <= '0;
			cur_mem_y  <= '0;
			hist_mem_x <= '0;
			hist_mem_y <= '0;
			done_write <= 1'b0;
		end else begin
			done_write <= start_write_mem;
			// new set lands in current, same edge as scoring
			if (new_set_from_dma && ready_new_set) begin
				for (int i = 0; i < PE_NUM; i++) begin
					cur_mem_x[base_addr + BBOX_ADDR_W'(i)] <= set_x[i];
					cur_mem_y[base_addr + BBOX_ADDR_W'(i)] <= set_y[i];
				end
			end
			// commit, whole frame becomes history
			if (start_write_mem) begin
				hist_mem_x <= cur_mem_x;
				hist_mem_y <= cur_mem_y;
			end
		end
	end

endmodule

//--- verilog/oflow_match_resolve.sv
// match flags and conflict scan
module oflow_match_resolve import oflow_core_pkg::*; import oflow_mem_pkg::*; (
	input  logic                           clk,
	input  logic                           reset_N,
	input  logic                           dist_valid,
	input  logic [SET_W-1:0]              set_index,
	input  logic [PE_NUM-1:0][DIST_W-1:0] lane_dist,
	input  logic [PE_NUM-1:0]             lane_valid,
	input  logic                           start_pe,
	input  logic                           start_cr,
	input  logic [BBOX_CNT_W-1:0]         num_of_bbox_in_frame,
	output logic [MAX_BBOX-1:0]           match_mask,
	output logic                           done_cr,
	output logic                           conflict_counter_th
);

	logic [BBOX_ADDR_W-1:0] wr_base;
	logic [BBOX_CNT_W-1:0]  scan_idx;
	logic [BBOX_CNT_W-1:0]  unmatched;
	logic                   scan_busy;

	// set_index has moved past the scored set by dist_valid
	assign wr_base = BBOX_ADDR_W'((set_index - 1'b1) * PE_NUM);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			match_mask <= '0;
		end else if (start_pe) begin
			match_mask <= '0;
		end else if (dist_valid) begin
			for (int i = 0; i < PE_NUM; i++)
				if (lane_valid[i])
					match_mask[wr_base + BBOX_ADDR_W'(i)] <= lane_dist[i] <= DIST_W'(MATCH_TH);
		end
	end

	// ------------------------------------------------------------------
	// scan all slots, one per cycle, then one result cycle
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			scan_busy           <= 1'b0;
			scan_idx            <= '0;
			unmatched           <= '0;
			done_cr             <= 1'b0;
			conflict_counter_th <= 1'b0;
		end else begin
			done_cr             <= 1'b0;
			conflict_counter_th <= 1'b0;
			if (start_cr) begin
				scan_busy <= 1'b1;
				scan_idx  <= '0;
				unmatched <= '0;
			end else if (scan_busy && scan_idx == BBOX_CNT_W'(MAX_BBOX)) begin
				scan_busy           <= 1'b0;
				// too many lost boxes, frame is dropped
				conflict_counter_th <= unmatched > BBOX_CNT_W'(CONFLICT_TH);
				done_cr             <= unmatched <= BBOX_CNT_W'(CONFLICT_TH);
			end else if (scan_busy) begin
				scan_idx <= scan_idx + 1'b1;
				// only slots inside this frame count
				if (scan_idx < num_of_bbox_in_frame && !match_mask[scan_idx[BBOX_ADDR_W-1:0]])
					unmatched <= unmatched + 1'b1;
			end
		end
	end

endmodule

//--- verilog/oflow_mem_pkg.sv
// box memory and distance widths
package oflow_mem_pkg;

	// one box coordinate
	localparam int COORD_W = 8;

	// |dx| + |dy|, one carry bit over a coordinate
	localparam int DIST_W = 9;

	// slot address inside a frame
	localparam int BBOX_ADDR_W = 4;

	// distance at or below this counts as a match
	localparam int MATCH_TH = 16;

endpackage

//--- verilog/oflow_pe_engine.sv
// per lane distance scoring engine
module oflow_pe_engine import oflow_core_pkg::*; import oflow_mem_pkg::*; (
	input  logic                            clk,
	input  logic                            reset_N,
	input  logic                            start_pe,
	input  logic                            new_set_from_dma,
	input  logic                            ready_new_set,
	input  logic [PE_NUM-1:0][COORD_W-1:0] set_x,
	input  logic [PE_NUM-1:0][COORD_W-1:0] set_y,
	input  logic [PE_NUM-1:0][COORD_W-1:0] hist_x,
	input  logic [PE_NUM-1:0][COORD_W-1:0] hist_y,
	input  logic [SET_W-1:0]               num_of_sets,
	input  logic [BBOX_CNT_W-1:0]          counter_of_remain_bboxes,
	output logic [SET_W-1:0]               set_index,
	output logic [PE_NUM-1:0][DIST_W-1:0]  lane_dist,
	output logic [PE_NUM-1:0]              lane_valid,
	output logic                            dist_valid,
	output logic                            done_pe
);

	logic set_accept;

	function automatic logic [COORD_W-1:0] abs_diff(input logic [COORD_W-1:0] a,
	                                                input logic [COORD_W-1:0] b);
		return (a > b) ? a - b : b - a;
	endfunction

	assign set_accept = new_set_from_dma & ready_new_set;

	// manhattan distance per lane, lanes past the count marked invalid
	always_ff @(posedge clk) begin
		if (set_accept) begin
			for (int i = 0; i < PE_NUM; i++) begin
				lane_dist[i]  <= DIST_W'(abs_diff(set_x[i], hist_x[i]))
				               + DIST_W'(abs_diff(set_y[i], hist_y[i]));
				lane_valid[i] <= BBOX_CNT_W'(i) < counter_of_remain_bboxes;
			end
		end
	end

	// set counter, dist_valid one cycle after accept
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			set_index  <= '0;
			dist_valid <= 1'b0;
			done_pe    <= 1'b0;
		end else begin
			dist_valid <= set_accept;
			// during dist_valid set_index already counts the scored set
			done_pe    <= dist_valid && (set_index == num_of_sets);
			if (start_pe)
				set_index <= '0;
			else if (set_accept && set_index < num_of_sets)
				set_index <= set_index + 1'b1;
		end
	end

endmodule

//--- verilog/oflow_set_divider.sv
// sequential divider for sets per frame
module oflow_set_divider import oflow_core_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  start_div,
	input  logic [BBOX_CNT_W-1:0] dividend,
	output logic                  div_complete,
	output logic [BBOX_CNT_W-1:0] quotient,
	output logic [BBOX_CNT_W-1:0] remainder
);

	logic [BBOX_CNT_W-1:0] partial;
	logic [BBOX_CNT_W-1:0] step_cnt;
	logic                  busy;
	logic                  fits;

	// shift next dividend bit into the partial remainder
	assign partial = {remainder[BBOX_CNT_W-2:0], quotient[BBOX_CNT_W-1]};
	assign fits    = (partial >= BBOX_CNT_W'(PE_NUM));

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy         <= 1'b0;
			step_cnt     <= '0;
			quotient     <= '0;
			remainder    <= '0;
			div_complete <= 1'b0;
		end else if (start_div) begin
			// quotient reg starts as the dividend, shifts out msb first
			busy         <= 1'b1;
			step_cnt     <= BBOX_CNT_W'(BBOX_CNT_W);
			quotient     <= dividend;
			remainder    <= '0;
			div_complete <= 1'b0;
		end else if (busy && step_cnt == '0) begin
			// all bits done, hold complete until next start
			busy         <= 1'b0;
			div_complete <= 1'b1;
		end else if (busy) begin
			// restoring step, one quotient bit per cycle
			step_cnt  <= step_cnt - 1'b1;
			quotient  <= {quotient[BBOX_CNT_W-2:0], fits};
			remainder <= fits ? partial - BBOX_CNT_W'(PE_NUM) : partial;
		end
	end

endmodule
